//--- design/tpu_pkg.sv
`default_nettype none

package tpu_pkg;

    // array geometry
    localparam int TILE_N     = 4;
    localparam int DATA_W     = 8;   // signed activations and weights
    localparam int ACC_W      = 24;  // signed accumulator words

    // accumulator memory
    localparam int ACC_DEPTH  = 64;
    localparam int ACC_ADDR_W = 6;

    localparam int VEC_CNT_W  = 7;   // 1 to 64 vectors per command

    // lane 0 in to column 0 out, skew input stage plus one hop per row
    localparam int ARRAY_LAT  = TILE_N + 1;

    localparam int ROW_CNT_W  = $clog2(TILE_N);
    localparam int WAVE_W     = VEC_CNT_W + 1;  // room for V + TILE_N - 2 and a sign

    typedef logic signed [ACC_W-1:0] acc_word_t;
    typedef logic [ACC_ADDR_W-1:0]   acc_addr_t;
    typedef logic [ROW_CNT_W-1:0]    row_cnt_t;
    typedef logic [WAVE_W-1:0]       wave_t;

    // write mode of a compute command
    typedef enum logic {
        ACC_OVERWRITE = 1'b0,
        ACC_ADD       = 1'b1
    } acc_mode_t;

endpackage

`default_nettype wire

//--- design/input_skew.sv
`timescale 1ns/10ps
`default_nettype none

module input_skew (
    input  logic                                             clk_i,
    input  logic                                             rst_n_i,
    input  logic                                             act_valid_i,
    input  logic [tpu_pkg::TILE_N-1:0][tpu_pkg::DATA_W-1:0]  act_row_i,
    output logic [tpu_pkg::TILE_N-1:0][tpu_pkg::DATA_W-1:0]  skew_act_o
);

    // triangular delay line, every lane shares the input stage
    // and lane k then waits k more cycles
    for (genvar k = 0; k < tpu_pkg::TILE_N; k++) begin : g_lane
        logic [tpu_pkg::DATA_W-1:0] pipe_q [k+1];

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                pipe_q <= '{default: '0};
            end else begin
                pipe_q[0] <= act_valid_i ? act_row_i[k] : '0;  // zeros between streams
                for (int i = 1; i <= k; i++) begin
                    pipe_q[i] <= pipe_q[i-1];
                end
            end
        end

        assign skew_act_o[k] = pipe_q[k];
    end

endmodule

`default_nettype wire

//--- design/mac_cell.sv
`timescale 1ns/10ps
`default_nettype none

module mac_cell (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               weight_we_i,
    input  logic signed [tpu_pkg::DATA_W-1:0]  weight_i,
    input  logic signed [tpu_pkg::DATA_W-1:0]  act_i,
    input  logic signed [tpu_pkg::ACC_W-1:0]   psum_i,
    output logic signed [tpu_pkg::DATA_W-1:0]  act_o,
    output logic signed [tpu_pkg::ACC_W-1:0]   psum_o
);

    logic signed [tpu_pkg::DATA_W-1:0]   weight_q;
    logic signed [2*tpu_pkg::DATA_W-1:0] prod;

    // stationary weight, kept across commands
    always_ff @(posedge clk_i) begin
        if (weight_we_i) begin
            weight_q <= weight_i;
        end
    end

    assign prod = act_i * weight_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            act_o  <= '0;
            psum_o <= '0;
        end else begin
            act_o  <= act_i;                                   // on to the right
            psum_o <= psum_i + tpu_pkg::acc_word_t'(prod);     // and down
        end
    end

endmodule

`default_nettype wire

//--- design/systolic_array.sv
`timescale 1ns/10ps
`default_nettype none

module systolic_array (
    input  logic                                             clk_i,
    input  logic                                             rst_n_i,
    input  logic                                             weight_load_i,
    input  logic [tpu_pkg::TILE_N-1:0][tpu_pkg::DATA_W-1:0]  weight_row_i,
    input  logic [tpu_pkg::TILE_N-1:0][tpu_pkg::DATA_W-1:0]  skew_act_i,
    output logic [tpu_pkg::TILE_N-1:0][tpu_pkg::ACC_W-1:0]   col_sum_o
);

    tpu_pkg::row_cnt_t row_q;  // next weight row to write

    // horizontal activation links and vertical partial sum links
    logic [tpu_pkg::DATA_W-1:0] act_link  [tpu_pkg::TILE_N][tpu_pkg::TILE_N+1];
    logic [tpu_pkg::ACC_W-1:0]  psum_link [tpu_pkg::TILE_N+1][tpu_pkg::TILE_N];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            row_q <= '0;
        end else if (weight_load_i) begin
            if (row_q == tpu_pkg::row_cnt_t'(tpu_pkg::TILE_N - 1)) begin
                row_q <= '0;
            end else begin
                row_q <= row_q + 1'b1;
            end
        end
    end

    for (genvar r = 0; r < tpu_pkg::TILE_N; r++) begin : g_row
        assign act_link[r][0] = skew_act_i[r];  // lane r feeds row r

        for (genvar c = 0; c < tpu_pkg::TILE_N; c++) begin : g_col
            mac_cell i_mac_cell (
                .clk_i       (clk_i),
                .rst_n_i     (rst_n_i),
                .weight_we_i (weight_load_i && (row_q == tpu_pkg::row_cnt_t'(r))),
                .weight_i    (weight_row_i[c]),
                .act_i       (act_link[r][c]),
                .psum_i      (psum_link[r][c]),
                .act_o       (act_link[r][c+1]),
                .psum_o      (psum_link[r+1][c])
            );
        end
    end

    for (genvar c = 0; c < tpu_pkg::TILE_N; c++) begin : g_edge
        assign psum_link[0][c] = '0;
        assign col_sum_o[c]    = psum_link[tpu_pkg::TILE_N][c];  // bottom row
    end

endmodule

`default_nettype wire

//--- design/accumulator_control.sv
`timescale 1ns/10ps
`default_nettype none

module accumulator_control (
    input  logic                                                 clk_i,
    input  logic                                                 rst_n_i,
    input  logic                                                 cmd_valid_i,
    input  logic [tpu_pkg::VEC_CNT_W-1:0]                        cmd_vecs_i,
    input  logic [tpu_pkg::ACC_ADDR_W-1:0]                       cmd_base_i,
    input  tpu_pkg::acc_mode_t                                   cmd_mode_i,
    input  logic                                                 act_valid_i,
    output logic [tpu_pkg::TILE_N-1:0]                           wr_mask_o,
    output logic [tpu_pkg::TILE_N-1:0][tpu_pkg::ACC_ADDR_W-1:0]  wr_addr_o,
    output logic [tpu_pkg::TILE_N-1:0][tpu_pkg::ACC_ADDR_W-1:0]  rd_addr_o,
    output logic                                                 acc_add_o,
    output logic                                                 busy_o,
    output logic                                                 done_o
);

    typedef enum logic [2:0] {
        IDLE,
        FILL,
        PARTIAL,
        FULL,
        REVERSE_PARTIAL
    } state_t;

    state_t                          state_q;
    tpu_pkg::wave_t                  wave_q;    // wavefront index that is negative while filling
    logic                            done_q;

    // command fields
    logic [tpu_pkg::VEC_CNT_W-1:0]   vecs_q;
    tpu_pkg::acc_addr_t              base_q;
    tpu_pkg::acc_mode_t              mode_q;

    tpu_pkg::wave_t                  wave_nxt;
    tpu_pkg::wave_t                  last_wave;
    logic                            writing;
    tpu_pkg::wave_t [tpu_pkg::TILE_N-1:0] row_idx;
    tpu_pkg::wave_t [tpu_pkg::TILE_N-1:0] wide_addr;

    assign wave_nxt  = wave_q + 1'b1;
    assign last_wave = tpu_pkg::wave_t'(vecs_q) + tpu_pkg::wave_t'(tpu_pkg::TILE_N - 2);
    assign writing   = state_q inside {PARTIAL, FULL, REVERSE_PARTIAL};

    always_ff @(posedge clk_i) begin
        if (cmd_valid_i && !busy_o) begin
            vecs_q <= cmd_vecs_i;
            base_q <= cmd_base_i;
            mode_q <= cmd_mode_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            wave_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (state_q != IDLE) begin
                wave_q <= wave_nxt;
            end
            case (state_q)
                IDLE: begin
                    if (cmd_valid_i) begin
                        state_q <= FILL;
                        wave_q  <= -tpu_pkg::wave_t'(tpu_pkg::ARRAY_LAT);
                    end
                end
                FILL: begin
                    if (wave_q == '1) begin  // column 0 of vector 0 arrives next
                        state_q <= PARTIAL;
                    end
                end
                PARTIAL: begin
                    // short commands never fill every lane
                    if (wave_nxt == tpu_pkg::wave_t'(vecs_q)) begin
                        state_q <= REVERSE_PARTIAL;
                    end else if (wave_nxt == tpu_pkg::wave_t'(tpu_pkg::TILE_N - 1)) begin
                        state_q <= FULL;
                    end
                end
                FULL: begin
                    if (wave_nxt == tpu_pkg::wave_t'(vecs_q)) begin
                        state_q <= REVERSE_PARTIAL;
                    end
                end
                REVERSE_PARTIAL: begin
                    if (wave_q == last_wave) begin  // last lane, last vector
                        state_q <= IDLE;
                        done_q  <= 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // lane j lags the wavefront by j rows
    always_comb begin
        for (int j = 0; j < tpu_pkg::TILE_N; j++) begin
            row_idx[j]   = wave_q - tpu_pkg::wave_t'(j);
            wide_addr[j] = tpu_pkg::wave_t'(base_q) + row_idx[j];
            wr_mask_o[j] = writing && !row_idx[j][tpu_pkg::WAVE_W-1]
                           && (row_idx[j] < tpu_pkg::wave_t'(vecs_q));
            wr_addr_o[j] = wide_addr[j][tpu_pkg::ACC_ADDR_W-1:0];
            // one row ahead so the old word is ready for an add
            rd_addr_o[j] = base_q + wave_nxt[tpu_pkg::ACC_ADDR_W-1:0]
                           - tpu_pkg::acc_addr_t'(j);
        end
    end

    assign acc_add_o = writing && (mode_q == tpu_pkg::ACC_ADD);
    assign busy_o    = (state_q != IDLE);
    assign done_o    = done_q;

    a_no_cmd_while_busy: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) cmd_valid_i |-> !busy_o
    ) else $error("command issued while busy");

    // a stream may only start right after its command, so a gap is caught on resume
    a_act_contiguous: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) $rose(act_valid_i) |-> $past(cmd_valid_i)
    ) else $error("activation stream not contiguous with its command");

    // the cycle before done only the top lane still writes its last row
    a_done_single: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        done_o |-> ($past(wr_mask_o) == {1'b1, {(tpu_pkg::TILE_N-1){1'b0}}}) ##1 !done_o
    ) else $error("done not a single pulse right after the last lane write");

    for (genvar j = 0; j < tpu_pkg::TILE_N; j++) begin : g_chk
        // command must not run past the end of the bank
        a_addr_range: assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            wr_mask_o[j] |-> (wide_addr[j] < tpu_pkg::wave_t'(tpu_pkg::ACC_DEPTH))
        ) else $error("write address beyond accumulator depth on lane %0d", j);
    end

endmodule

`default_nettype wire

//--- design/accumulator_bank.sv
`timescale 1ns/10ps
`default_nettype none

module accumulator_bank (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            wr_en_i,
    input  logic [tpu_pkg::ACC_ADDR_W-1:0]  wr_addr_i,
    input  logic [tpu_pkg::ACC_ADDR_W-1:0]  rd_addr_i,
    input  logic                            acc_add_i,
    input  logic [tpu_pkg::ACC_W-1:0]       sum_i,
    input  logic                            host_rd_en_i,
    input  logic [tpu_pkg::ACC_ADDR_W-1:0]  host_rd_addr_i,
    output logic [tpu_pkg::ACC_W-1:0]       rd_data_o,
    output logic                            rd_valid_o
);

    logic [tpu_pkg::ACC_W-1:0] mem_q [tpu_pkg::ACC_DEPTH];
    logic [tpu_pkg::ACC_W-1:0] rd_q;       // old word for add, or host data
    logic                      rd_valid_q;

    // one read port, the host only gets it between commands
    always_ff @(posedge clk_i) begin
        if (host_rd_en_i) begin
            rd_q <= mem_q[host_rd_addr_i];
        end else begin
            rd_q <= mem_q[rd_addr_i];
        end
        if (wr_en_i) begin
            mem_q[wr_addr_i] <= acc_add_i ? rd_q + sum_i : sum_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= host_rd_en_i;
        end
    end

    assign rd_data_o  = rd_q;
    assign rd_valid_o = rd_valid_q;

    a_no_host_rd_during_wr: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) host_rd_en_i |-> !wr_en_i
    ) else $error("host read while the bank is being written");

endmodule

`default_nettype wire

//--- design/tpu_mini_top.sv
`timescale 1ns/10ps
`default_nettype none

module tpu_mini_top (
    input  logic                                             clk_i,
    input  logic                                             rst_n_i,
    input  logic                                             weight_load_i,
    input  logic [tpu_pkg::TILE_N-1:0][tpu_pkg::DATA_W-1:0]  weight_row_i,
    input  logic                                             cmd_valid_i,
    input  logic [tpu_pkg::VEC_CNT_W-1:0]                    cmd_vecs_i,
    input  logic [tpu_pkg::ACC_ADDR_W-1:0]                   cmd_base_i,
    input  tpu_pkg::acc_mode_t                               cmd_mode_i,
    input  logic                                             act_valid_i,
    input  logic [tpu_pkg::TILE_N-1:0][tpu_pkg::DATA_W-1:0]  act_row_i,
    input  logic                                             rd_en_i,
    input  logic [tpu_pkg::ACC_ADDR_W-1:0]                   rd_addr_i,
    output logic [tpu_pkg::TILE_N-1:0][tpu_pkg::ACC_W-1:0]   rd_data_o,
    output logic                                             rd_valid_o,
    output logic                                             busy_o,
    output logic                                             done_o
);

    logic [tpu_pkg::TILE_N-1:0][tpu_pkg::DATA_W-1:0]      skew_act;
    logic [tpu_pkg::TILE_N-1:0][tpu_pkg::ACC_W-1:0]       col_sum;
    logic [tpu_pkg::TILE_N-1:0]                           wr_mask;
    logic [tpu_pkg::TILE_N-1:0][tpu_pkg::ACC_ADDR_W-1:0]  wr_addr;
    logic [tpu_pkg::TILE_N-1:0][tpu_pkg::ACC_ADDR_W-1:0]  rd_addr;
    logic                                                 acc_add;
    logic [tpu_pkg::TILE_N-1:0]                           bank_rd_valid;  // all banks in lockstep

    input_skew i_input_skew (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .act_valid_i (act_valid_i),
        .act_row_i   (act_row_i),
        .skew_act_o  (skew_act)
    );

    systolic_array i_systolic_array (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .weight_load_i (weight_load_i),
        .weight_row_i  (weight_row_i),
        .skew_act_i    (skew_act),
        .col_sum_o     (col_sum)
    );

    accumulator_control i_accumulator_control (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_vecs_i  (cmd_vecs_i),
        .cmd_base_i  (cmd_base_i),
        .cmd_mode_i  (cmd_mode_i),
        .act_valid_i (act_valid_i),
        .wr_mask_o   (wr_mask),
        .wr_addr_o   (wr_addr),
        .rd_addr_o   (rd_addr),
        .acc_add_o   (acc_add),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    // one bank per column
    for (genvar j = 0; j < tpu_pkg::TILE_N; j++) begin : g_bank
        accumulator_bank i_accumulator_bank (
            .clk_i          (clk_i),
            .rst_n_i        (rst_n_i),
            .wr_en_i        (wr_mask[j]),
            .wr_addr_i      (wr_addr[j]),
            .rd_addr_i      (rd_addr[j]),
            .acc_add_i      (acc_add),
            .sum_i          (col_sum[j]),
            .host_rd_en_i   (rd_en_i),
            .host_rd_addr_i (rd_addr_i),
            .rd_data_o      (rd_data_o[j]),
            .rd_valid_o     (bank_rd_valid[j])
        );
    end

    assign rd_valid_o = bank_rd_valid[0];

endmodule

`default_nettype wire

//--- tb/tpu_mini_vectors.svh
`ifndef TPU_MINI_VECTORS_SVH
`define TPU_MINI_VECTORS_SVH

typedef struct packed {
    logic [tpu_pkg::VEC_CNT_W-1:0]  vecs;
    logic [tpu_pkg::ACC_ADDR_W-1:0] base;
    tpu_pkg::acc_mode_t             mode;
    logic                           reload;  // load a fresh weight tile first
} cmd_entry_t;

localparam int NUM_TESTS = 9;

// columns: vector count, base row, write mode, reload weights
localparam cmd_entry_t [0:NUM_TESTS-1] TEST_TABLE = '{
    '{7'd64, 6'd0,  tpu_pkg::ACC_OVERWRITE, 1'b1},  // gives every row a known value
    '{7'd16, 6'd0,  tpu_pkg::ACC_OVERWRITE, 1'b0},
    '{7'd1,  6'd20, tpu_pkg::ACC_OVERWRITE, 1'b0},  // single vector
    '{7'd3,  6'd30, tpu_pkg::ACC_OVERWRITE, 1'b0},  // never reaches FULL
    '{7'd16, 6'd0,  tpu_pkg::ACC_ADD,       1'b0},  // onto the rows of test 1
    '{7'd4,  6'd40, tpu_pkg::ACC_OVERWRITE, 1'b1},
    '{7'd2,  6'd41, tpu_pkg::ACC_ADD,       1'b0},
    '{7'd5,  6'd59, tpu_pkg::ACC_OVERWRITE, 1'b0},  // up to the last row
    '{7'd1,  6'd0,  tpu_pkg::ACC_ADD,       1'b1}
};

`endif

//--- tb/tb_tpu_mini.sv
`timescale 1ns/10ps
`default_nettype none

module tb_tpu_mini;

    localparam int CLK_PERIOD = 40;
    localparam int N  = tpu_pkg::TILE_N;
    localparam int DW = tpu_pkg::DATA_W;
    localparam int AW = tpu_pkg::ACC_W;

    logic                           clk;
    logic                           rst_n;
    logic                           weight_load;
    logic [N-1:0][DW-1:0]           weight_row;
    logic                           cmd_valid;
    logic [tpu_pkg::VEC_CNT_W-1:0]  cmd_vecs;
    logic [tpu_pkg::ACC_ADDR_W-1:0] cmd_base;
    tpu_pkg::acc_mode_t             cmd_mode;
    logic                           act_valid;
    logic [N-1:0][DW-1:0]           act_row;
    logic                           rd_en;
    logic [tpu_pkg::ACC_ADDR_W-1:0] rd_addr;
    logic [N-1:0][AW-1:0]           rd_data;
    logic                           rd_valid;
    logic                           busy;
    logic                           done;

    `include "tpu_mini_vectors.svh"

    logic [31:0]          lfsr_q = 32'h88ae951e;
    logic signed [DW-1:0] w_ref   [N][N];                   // [k][j]
    logic signed [DW-1:0] act_ref [tpu_pkg::ACC_DEPTH][N];  // [r][k]
    logic [AW-1:0]        shadow  [tpu_pkg::ACC_DEPTH][N];  // expected bank contents
    int                   cycle_cnt = 0;
    int                   check_cnt = 0;
    int                   error_cnt = 0;

    tpu_mini_top i_tpu_mini_top (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .weight_load_i (weight_load),
        .weight_row_i  (weight_row),
        .cmd_valid_i   (cmd_valid),
        .cmd_vecs_i    (cmd_vecs),
        .cmd_base_i    (cmd_base),
        .cmd_mode_i    (cmd_mode),
        .act_valid_i   (act_valid),
        .act_row_i     (act_row),
        .rd_en_i       (rd_en),
        .rd_addr_i     (rd_addr),
        .rd_data_o     (rd_data),
        .rd_valid_o    (rd_valid),
        .busy_o        (busy),
        .done_o        (done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [DW-1:0] take_byte();
        logic [DW-1:0] bits;
        logic          fb;
        bits = '0;
        for (int i = 0; i < DW; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            bits   = {bits[DW-2:0], fb};
        end
        return bits;
    endfunction

    // column j of vector r is the dot product of the vector with weight column j
    function automatic logic [AW-1:0] product_ref(input int r, input int j);
        int sum;
        sum = 0;
        for (int k = 0; k < N; k++) begin
            sum += int'(act_ref[r][k]) * int'(w_ref[k][j]);
        end
        return sum[AW-1:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic load_weights();
        for (int k = 0; k < N; k++) begin
            @(posedge clk);
            weight_load <= 1'b1;
            for (int j = 0; j < N; j++) begin
                w_ref[k][j] = take_byte();
                weight_row[j] <= w_ref[k][j];
            end
        end
        @(posedge clk);
        weight_load <= 1'b0;
    endtask

    task automatic run_command(input cmd_entry_t e);
        int start_cnt;
        int row;
        for (int r = 0; r < int'(e.vecs); r++) begin
            for (int k = 0; k < N; k++) begin
                act_ref[r][k] = take_byte();
            end
        end
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_vecs  <= e.vecs;
        cmd_base  <= e.base;
        cmd_mode  <= e.mode;
        @(negedge clk);
        check_value("busy_o", 32'(busy), 32'd0);
        for (int r = 0; r < int'(e.vecs); r++) begin
            @(posedge clk);
            cmd_valid <= 1'b0;
            act_valid <= 1'b1;
            for (int k = 0; k < N; k++) begin
                act_row[k] <= act_ref[r][k];
            end
            @(negedge clk);
            if (r == 0) begin
                start_cnt = cycle_cnt;  // edge before the first activation is taken
            end
            check_value("busy_o", 32'(busy), 32'd1);
        end
        @(posedge clk);
        act_valid <= 1'b0;
        act_row   <= '0;
        @(negedge clk);
        while (done !== 1'b1) begin
            check_value("busy_o", 32'(busy), 32'd1);
            @(negedge clk);
        end
        check_value("done_o latency", 32'(cycle_cnt - start_cnt),
                    32'(tpu_pkg::ARRAY_LAT + int'(e.vecs) + N - 1));
        check_value("busy_o", 32'(busy), 32'd0);
        @(negedge clk);
        check_value("done_o", 32'(done), 32'd0);
        for (int r = 0; r < int'(e.vecs); r++) begin
            row = int'(e.base) + r;
            for (int j = 0; j < N; j++) begin
                if (e.mode == tpu_pkg::ACC_ADD) begin
                    shadow[row][j] = shadow[row][j] + product_ref(r, j);
                end else begin
                    shadow[row][j] = product_ref(r, j);
                end
            end
        end
    endtask

    // one host read per cycle, data and valid checked one cycle behind
    task automatic read_back(input int first, input int last);
        int n;
        int addr;
        n = last - first + 1;
        for (int i = 0; i <= n; i++) begin
            addr = first + i;
            @(posedge clk);
            rd_en   <= (i < n);
            rd_addr <= addr[tpu_pkg::ACC_ADDR_W-1:0];
            @(negedge clk);
            check_value("rd_valid_o", 32'(rd_valid), 32'(i > 0));
            for (int j = 0; j < N && i > 0; j++) begin
                check_value($sformatf("rd_data_o[%0d] row %0d", j, addr - 1),
                            32'(rd_data[j]), 32'(shadow[addr-1][j]));
            end
        end
        @(negedge clk);
        check_value("rd_valid_o", 32'(rd_valid), 32'd0);
    endtask

    initial begin : stimulus
        cmd_entry_t e;
        int         errors_before;
        rst_n       = 1'b0;
        weight_load = 1'b0;
        weight_row  = '0;
        cmd_valid   = 1'b0;
        cmd_vecs    = '0;
        cmd_base    = '0;
        cmd_mode    = tpu_pkg::ACC_OVERWRITE;
        act_valid   = 1'b0;
        act_row     = '0;
        rd_en       = 1'b0;
        rd_addr     = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("busy_o", 32'(busy), 32'd0);
        check_value("done_o", 32'(done), 32'd0);
        check_value("rd_valid_o", 32'(rd_valid), 32'd0);
        for (int t = 0; t < NUM_TESTS; t++) begin
            e             = TEST_TABLE[t];
            errors_before = error_cnt;
            if (e.reload) begin
                load_weights();
            end
            run_command(e);
            read_back((e.base > 0) ? int'(e.base) - 1 : 0,
                      (int'(e.base) + int'(e.vecs) < tpu_pkg::ACC_DEPTH) ?
                      int'(e.base) + int'(e.vecs) : tpu_pkg::ACC_DEPTH - 1);
            $display("test %0d: %0d vectors at row %0d, %s%s, %0d errors", t, e.vecs,
                     e.base, (e.mode == tpu_pkg::ACC_ADD) ? "add" : "overwrite",
                     e.reload ? ", new weights" : "", error_cnt - errors_before);
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin : watchdog
        longint budget;
        budget = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            budget += longint'(TEST_TABLE[t].vecs) + tpu_pkg::ARRAY_LAT + 2 * N + 10;
        end
        #(budget * CLK_PERIOD * 2);
        $display("timeout: done_o never arrived, run stopped at %0t", $time);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tpu_mini.f
+incdir+tb
design/tpu_pkg.sv
design/input_skew.sv
design/mac_cell.sv
design/systolic_array.sv
design/accumulator_control.sv
design/accumulator_bank.sv
design/tpu_mini_top.sv
tb/tb_tpu_mini.sv

//--- Makefile
# Verilator build and run for the tpu_mini testbench

VERILATOR ?= verilator
TOP       ?= tb_tpu_mini
FILELIST  ?= tpu_mini.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/10ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
